/* Makefile */
LOG = sim.log

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f filelist.f --top-module tb_rxfe

run: build
	./obj_dir/Vtb_rxfe | tee $(LOG)
	grep -q "all tests passed" $(LOG)

lint:
	verilator --lint-only -Wall --timing -f filelist.f --top-module tb_rxfe

clean:
	rm -rf obj_dir $(LOG)

/* filelist.f */
rxfe_pkg.sv
rxfe_cmd_regs.sv
rxfe_burst_framer.sv
rxfe_chan_mux.sv
rxfe_word_packer.sv
rxfe_ring_ptrs.sv
rxfe_top.sv
tb_rxfe.sv

/* rxfe_burst_framer.sv */
`default_nettype none

module rxfe_burst_framer
  import rxfe_pkg::*;
(
  input  logic                      clk,
  input  logic                      clk_burst_rst,
  input  logic                      in_valid_i,
  input  logic [LANES*SAMPLE_W-1:0] in_data_i,
  input  rx_cfg_t                   cfg_i,
  input  logic                      running_i,
  input  logic                      burster_rst_i,
  output lanes_t                    lanes_o,
  output logic                      beat_valid_o,
  output logic                      beat_last_o
);

  typedef enum logic {
    PH_SEND,
    PH_SKIP
  } phase_e;

  word_addr_t              sample_cnt_q;
  logic [WORD_ADDR_BITS:0] sample_nxt;
  logic [7:0]              burst_cnt_q;
  logic [8:0]              burst_nxt;
  phase_e                  phase_q;
  logic                    advance;
  logic                    burst_end;

  function automatic lane_t align(input logic [SAMPLE_W-1:0] s);
    return {s, {(16-SAMPLE_W){1'b0}}};
  endfunction

  assign lanes_o.ai = align(in_data_i[0*SAMPLE_W +: SAMPLE_W]);
  assign lanes_o.aq = align(in_data_i[1*SAMPLE_W +: SAMPLE_W]);
  assign lanes_o.bi = align(in_data_i[2*SAMPLE_W +: SAMPLE_W]);
  assign lanes_o.bq = align(in_data_i[3*SAMPLE_W +: SAMPLE_W]);

  assign advance    = in_valid_i && running_i && !burster_rst_i;
  // Borrow out of the down counter marks the last beat
  assign sample_nxt = {1'b0, sample_cnt_q} - (WORD_ADDR_BITS+1)'(1);
  assign burst_end  = sample_nxt[WORD_ADDR_BITS];
  assign burst_nxt  = {1'b0, burst_cnt_q} - 9'd1;

  always_ff @(posedge clk) begin
    if (clk_burst_rst || burster_rst_i) begin
      sample_cnt_q <= cfg_i.samples_z;
      burst_cnt_q  <= '0;
      phase_q      <= PH_SEND;
    end else if (advance) begin
      if (burst_end) begin
        sample_cnt_q <= cfg_i.samples_z;
        if (cfg_i.throttle_en) begin
          if (burst_nxt[8]) begin
            phase_q     <= (phase_q == PH_SEND) ? PH_SKIP : PH_SEND;
            burst_cnt_q <= (phase_q == PH_SEND) ? cfg_i.num_skip : cfg_i.num_send;
          end else begin
            burst_cnt_q <= burst_nxt[7:0];
          end
        end
      end else begin
        sample_cnt_q <= sample_nxt[WORD_ADDR_BITS-1:0];
      end
    end
  end

  assign beat_valid_o = advance && !(cfg_i.throttle_en && (phase_q == PH_SKIP));
  assign beat_last_o  = burst_end;

endmodule

`default_nettype wire

/* rxfe_chan_mux.sv */
`default_nettype none

module rxfe_chan_mux
  import rxfe_pkg::*;
(
  input  logic       clk,
  input  logic       clk_burst_rst,
  input  lanes_t     lanes_i,
  input  logic       beat_valid_i,
  input  logic       beat_last_i,
  input  ch_fmt_e    ch_fmt_i,
  output iq_pair_t   pair_o,
  output logic [3:0] ch_enabled_o
);

  lane_t [3:0] ch_val;
  logic [3:0]  ch_mask;
  logic [1:0]  lo_idx;
  logic [1:0]  hi_idx;
  logic        four_ch;
  logic        two_ch;
  logic        pair_full;
  logic [1:0]  pidx_q;
  logic        valid_q;
  logic        last_q;
  lane_t       d0_i_q;
  lane_t       d0_q_q;
  lane_t       d1_i_q;
  lane_t       d1_q_q;

  function automatic logic [1:0] first_ch(input logic [3:0] mask);
    logic [1:0] idx;
    idx = 2'd0;
    for (int k = 3; k >= 0; k--) begin
      if (mask[k]) begin
        idx = 2'(k);
      end
    end
    return idx;
  endfunction

  function automatic logic [1:0] last_ch(input logic [3:0] mask);
    logic [1:0] idx;
    idx = 2'd0;
    for (int k = 0; k < 4; k++) begin
      if (mask[k]) begin
        idx = 2'(k);
      end
    end
    return idx;
  endfunction

  always_comb begin
    case (ch_fmt_i)
      CH_3210: ch_mask = 4'b1111;
      CH_XX10: ch_mask = 4'b0011;
      CH_XXX0: ch_mask = 4'b0001;
      CH_XX1X: ch_mask = 4'b0010;
      CH_X2X0: ch_mask = 4'b0101;
      CH_32XX: ch_mask = 4'b1100;
      CH_X2XX: ch_mask = 4'b0100;
      CH_3XXX: ch_mask = 4'b1000;
    endcase
  end

  // One value per channel
  assign ch_val = {lanes_i.bq, lanes_i.bi, lanes_i.aq, lanes_i.ai};

  assign lo_idx    = first_ch(ch_mask);
  assign hi_idx    = last_ch(ch_mask);
  assign four_ch   = (ch_fmt_i == CH_3210);
  assign two_ch    = (ch_fmt_i == CH_XX10) || (ch_fmt_i == CH_X2X0) || (ch_fmt_i == CH_32XX);
  assign pair_full = four_ch || (two_ch ? pidx_q[0] : (pidx_q == 2'd3));

  always_ff @(posedge clk) begin
    if (clk_burst_rst) begin
      pidx_q  <= '0;
      valid_q <= 1'b0;
      last_q  <= 1'b0;
    end else begin
      valid_q <= beat_valid_i && (beat_last_i || pair_full);
      last_q  <= beat_last_i;
      if (beat_valid_i) begin
        pidx_q <= beat_last_i ? 2'd0 : pidx_q + 2'd1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (beat_valid_i) begin
      if (four_ch) begin
        d0_i_q <= ch_val[0];
        d0_q_q <= ch_val[1];
        d1_i_q <= ch_val[2];
        d1_q_q <= ch_val[3];
      end else if (two_ch) begin
        if (!pidx_q[0]) begin
          d0_i_q <= ch_val[lo_idx];
          d0_q_q <= ch_val[hi_idx];
        end else begin
          d1_i_q <= ch_val[lo_idx];
          d1_q_q <= ch_val[hi_idx];
        end
      end else begin
        // Single channel fills I slots first
        case (pidx_q)
          2'd0: d0_i_q <= ch_val[lo_idx];
          2'd1: d1_i_q <= ch_val[lo_idx];
          2'd2: d0_q_q <= ch_val[lo_idx];
          2'd3: d1_q_q <= ch_val[lo_idx];
        endcase
      end
    end
  end

  assign pair_o = '{
    d0_i:  d0_i_q,
    d0_q:  d0_q_q,
    d1_i:  d1_i_q,
    d1_q:  d1_q_q,
    valid: valid_q,
    last:  last_q
  };
  assign ch_enabled_o = ch_mask;

endmodule

`default_nettype wire

/* rxfe_cmd_regs.sv */
`default_nettype none

module rxfe_cmd_regs
  import rxfe_pkg::*;
(
  input  logic        clk,
  input  logic        clk_burst_rst,
  input  logic        cmd_valid_i,
  input  logic [31:0] cmd_data_i,
  input  logic        timer_rst_i,
  output rx_cfg_t     cfg_o,
  output logic        running_o,
  output logic        burster_rst_o,
  output logic        phy_enable_o,
  output logic        test_pattern_o
);

  rx_cfg_t     cfg_q;
  stream_cmd_e stream_cmd_q;
  logic        running_q;
  logic        burster_rst_q;
  logic        enable_q;
  logic        test_pattern_q;
  cmd_op_e     op;
  logic        stream_fire;

  assign op = cmd_op_e'(cmd_data_i[CMD_OP_LSB +: 4]);

  // Pending command waits for the timer reset to drop
  assign stream_fire = !timer_rst_i && (stream_cmd_q != IDLE);

  always_ff @(posedge clk) begin
    if (clk_burst_rst) begin
      cfg_q.samples_z    <= word_addr_t'(511);
      cfg_q.in_fmt       <= FMT_16BIT;
      cfg_q.ch_fmt       <= CH_3210;
      cfg_q.words_z      <= '0;
      cfg_q.total_bursts <= '0;
      cfg_q.throttle_en  <= 1'b0;
      cfg_q.num_send     <= '0;
      cfg_q.num_skip     <= '0;
      stream_cmd_q       <= IDLE;
      running_q          <= 1'b0;
      burster_rst_q      <= 1'b1;
      enable_q           <= 1'b1;
      test_pattern_q     <= 1'b0;
    end else begin
      if (stream_fire) begin
        running_q    <= (stream_cmd_q == START_AT) || (stream_cmd_q == START_IMM);
        stream_cmd_q <= IDLE;
      end

      if (cmd_valid_i) begin
        case (op)
          CMD_BURST_SAMPLES: begin
            cfg_q.samples_z <= cmd_data_i[12:0];
          end
          CMD_BURST_FORMAT: begin
            cfg_q.in_fmt       <= in_fmt_e'(cmd_data_i[1:0]);
            cfg_q.ch_fmt       <= ch_fmt_e'(cmd_data_i[4:2]);
            cfg_q.words_z      <= cmd_data_i[17:5];
            cfg_q.total_bursts <= cmd_data_i[27:18];
          end
          CMD_BURST_THROTTLE: begin
            cfg_q.num_skip    <= cmd_data_i[7:0];
            cfg_q.num_send    <= cmd_data_i[15:8];
            cfg_q.throttle_en <= cmd_data_i[16];
          end
          CMD_RESET: begin
            burster_rst_q  <= cmd_data_i[15];
            // Immediate stop wins over a pending start
            if (cmd_data_i[14]) begin
              running_q <= 1'b0;
            end
            enable_q       <= cmd_data_i[13];
            test_pattern_q <= cmd_data_i[12];
            stream_cmd_q   <= stream_cmd_e'(cmd_data_i[2:0]);
          end
          default: ;
        endcase
      end
    end
  end

  assign cfg_o          = cfg_q;
  assign running_o      = running_q;
  assign burster_rst_o  = burster_rst_q;
  assign phy_enable_o   = ~enable_q;
  assign test_pattern_o = test_pattern_q;

  a_stream_cmd_legal: assert property (
    @(posedge clk) disable iff (clk_burst_rst) stream_cmd_q <= STOP_IMM
  );

endmodule

`default_nettype wire

/* rxfe_pkg.sv */
`default_nettype none

package rxfe_pkg;

  localparam int BUF_ADDR_BITS  = 16;
  localparam int WORD_ADDR_BITS = BUF_ADDR_BITS - 3;
  // Wrap bit included
  localparam int BURST_PTR_BITS = BUF_ADDR_BITS - 5;
  localparam int SAMPLE_W       = 12;
  localparam int LANES          = 4;
  localparam int CMD_OP_LSB     = 28;

  typedef logic [WORD_ADDR_BITS-1:0] word_addr_t;
  typedef logic [BURST_PTR_BITS-1:0] burst_ptr_t;
  typedef logic [15:0]               lane_t;

  typedef enum logic [3:0] {
    CMD_BURST_SAMPLES  = 4'd0,
    CMD_BURST_FORMAT   = 4'd1,
    CMD_BURST_THROTTLE = 4'd2,
    CMD_RESET          = 4'd3
  } cmd_op_e;

  // Codes 0 and 2 are reserved
  typedef enum logic [1:0] {
    FMT_8BIT  = 2'd1,
    FMT_16BIT = 2'd3
  } in_fmt_e;

  typedef enum logic [2:0] {
    CH_3210 = 3'd0,
    CH_XX10 = 3'd1,
    CH_XXX0 = 3'd2,
    CH_XX1X = 3'd3,
    CH_X2X0 = 3'd4,
    CH_32XX = 3'd5,
    CH_X2XX = 3'd6,
    CH_3XXX = 3'd7
  } ch_fmt_e;

  typedef enum logic [2:0] {
    IDLE      = 3'd0,
    START_AT  = 3'd1,
    START_IMM = 3'd2,
    STOP_AT   = 3'd3,
    STOP_IMM  = 3'd4
  } stream_cmd_e;

  typedef struct packed {
    lane_t ai;
    lane_t aq;
    lane_t bi;
    lane_t bq;
  } lanes_t;

  typedef struct packed {
    word_addr_t                samples_z;
    in_fmt_e                   in_fmt;
    ch_fmt_e                   ch_fmt;
    word_addr_t                words_z;
    logic [BURST_PTR_BITS-2:0] total_bursts;
    logic                      throttle_en;
    logic [7:0]                num_send;
    logic [7:0]                num_skip;
  } rx_cfg_t;

  typedef struct packed {
    lane_t d0_i;
    lane_t d0_q;
    lane_t d1_i;
    lane_t d1_q;
    logic  valid;
    logic  last;
  } iq_pair_t;

  typedef struct packed {
    logic       valid;
    word_addr_t addr;
    logic [63:0] data;
    logic [7:0] keep;
    logic       last;
  } ram_wr_t;

endpackage

`default_nettype wire

/* rxfe_ring_ptrs.sv */
`default_nettype none

module rxfe_ring_ptrs
  import rxfe_pkg::*;
(
  input  logic                      clk,
  input  logic                      clk_burst_rst,
  input  logic [BURST_PTR_BITS-2:0] total_bursts_i,
  input  logic                      burst_done_i,
  input  logic                      release_i,
  output burst_ptr_t                avail_z_o,
  output logic                      fill_o,
  output logic                      full_o
);

  burst_ptr_t wptr_q;
  burst_ptr_t rptr_q;
  burst_ptr_t room_z;

  always_ff @(posedge clk) begin
    if (clk_burst_rst) begin
      wptr_q <= '0;
      rptr_q <= '0;
    end else begin
      if (burst_done_i) begin
        wptr_q <= wptr_q + burst_ptr_t'(1);
      end
      if (release_i) begin
        rptr_q <= rptr_q + burst_ptr_t'(1);
      end
    end
  end

  assign avail_z_o = wptr_q - rptr_q - burst_ptr_t'(1);
  // Negative free space means full
  assign room_z    = {1'b0, total_bursts_i} + rptr_q - wptr_q - burst_ptr_t'(1);
  assign full_o    = room_z[BURST_PTR_BITS-1];
  assign fill_o    = wptr_q[0];

endmodule

`default_nettype wire

/* rxfe_top.sv */
`default_nettype none

module rxfe_top
  import rxfe_pkg::*;
(
  input  logic                      clk,
  input  logic                      clk_burst_rst,
  input  logic                      cmd_valid_i,
  input  logic [31:0]               cmd_data_i,
  input  logic                      timer_rst_i,
  input  logic                      in_valid_i,
  input  logic [LANES*SAMPLE_W-1:0] in_data_i,
  input  logic                      release_i,
  output ram_wr_t                   m_wr_o,
  output logic                      running_o,
  output logic                      phy_enable_o,
  output logic                      test_pattern_o,
  output logic [3:0]                ch_enabled_o,
  output burst_ptr_t                avail_z_o,
  output logic                      fill_o,
  output logic                      skip_o
);

  rx_cfg_t  cfg;
  logic     running;
  logic     burster_rst;
  lanes_t   lanes;
  logic     beat_valid;
  logic     beat_last;
  iq_pair_t pair;
  logic     burst_done;
  logic     full;

  assign running_o = running;

  rxfe_cmd_regs u_cmd_regs (
    .clk            (clk),
    .clk_burst_rst  (clk_burst_rst),
    .cmd_valid_i    (cmd_valid_i),
    .cmd_data_i     (cmd_data_i),
    .timer_rst_i    (timer_rst_i),
    .cfg_o          (cfg),
    .running_o      (running),
    .burster_rst_o  (burster_rst),
    .phy_enable_o   (phy_enable_o),
    .test_pattern_o (test_pattern_o)
  );

  rxfe_burst_framer u_framer (
    .clk           (clk),
    .clk_burst_rst (clk_burst_rst),
    .in_valid_i    (in_valid_i),
    .in_data_i     (in_data_i),
    .cfg_i         (cfg),
    .running_i     (running),
    .burster_rst_i (burster_rst),
    .lanes_o       (lanes),
    .beat_valid_o  (beat_valid),
    .beat_last_o   (beat_last)
  );

  rxfe_chan_mux u_mux (
    .clk           (clk),
    .clk_burst_rst (clk_burst_rst),
    .lanes_i       (lanes),
    .beat_valid_i  (beat_valid),
    .beat_last_i   (beat_last),
    .ch_fmt_i      (cfg.ch_fmt),
    .pair_o        (pair),
    .ch_enabled_o  (ch_enabled_o)
  );

  rxfe_word_packer u_packer (
    .clk           (clk),
    .clk_burst_rst (clk_burst_rst),
    .pair_i        (pair),
    .in_fmt_i      (cfg.in_fmt),
    .words_z_i     (cfg.words_z),
    .full_i        (full),
    .wr_o          (m_wr_o),
    .burst_done_o  (burst_done),
    .skip_toggle_o (skip_o)
  );

  rxfe_ring_ptrs u_ring (
    .clk            (clk),
    .clk_burst_rst  (clk_burst_rst),
    .total_bursts_i (cfg.total_bursts),
    .burst_done_i   (burst_done),
    .release_i      (release_i),
    .avail_z_o      (avail_z_o),
    .fill_o         (fill_o),
    .full_o         (full)
  );

endmodule

`default_nettype wire

/* rxfe_word_packer.sv */
`default_nettype none

module rxfe_word_packer
  import rxfe_pkg::*;
(
  input  logic       clk,
  input  logic       clk_burst_rst,
  input  iq_pair_t   pair_i,
  input  in_fmt_e    in_fmt_i,
  input  word_addr_t words_z_i,
  input  logic       full_i,
  output ram_wr_t    wr_o,
  output logic       burst_done_o,
  output logic       skip_toggle_o
);

  logic [31:0] half8;
  logic        word_valid;
  logic        skip_now;
  logic        half_q;
  logic        first_q;
  logic        skip_q;
  logic        toggle_q;
  word_addr_t  base_q;
  word_addr_t  wcnt_q;
  logic        wr_valid_q;
  word_addr_t  wr_addr_q;
  logic [63:0] wr_data_q;
  logic [7:0]  wr_keep_q;
  logic        wr_last_q;

  assign half8 = {pair_i.d1_q[15:8], pair_i.d1_i[15:8], pair_i.d0_q[15:8], pair_i.d0_i[15:8]};

  always_comb begin
    case (in_fmt_i)
      FMT_16BIT: word_valid = pair_i.valid;
      FMT_8BIT:  word_valid = pair_i.valid && (half_q || pair_i.last);
      default:   word_valid = 1'b0;
    endcase
  end

  // Full is only looked at on the first word of a burst
  assign skip_now     = first_q ? full_i : skip_q;
  assign burst_done_o = word_valid && pair_i.last && !skip_now;

  ////////////////////
  // Burst sequencing

  always_ff @(posedge clk) begin
    if (clk_burst_rst) begin
      half_q     <= 1'b0;
      first_q    <= 1'b1;
      skip_q     <= 1'b0;
      toggle_q   <= 1'b0;
      base_q     <= '0;
      wcnt_q     <= '0;
      wr_valid_q <= 1'b0;
    end else begin
      wr_valid_q <= word_valid && !skip_now;

      if (pair_i.valid && (in_fmt_i == FMT_8BIT)) begin
        half_q <= !half_q && !pair_i.last;
      end

      if (word_valid) begin
        first_q <= pair_i.last;
        skip_q  <= skip_now;
        wcnt_q  <= pair_i.last ? '0 : wcnt_q + word_addr_t'(1);
        if (pair_i.last) begin
          toggle_q <= toggle_q ^ skip_now;
          if (!skip_now) begin
            base_q <= base_q + words_z_i + word_addr_t'(1);
          end
        end
      end
    end
  end

  ////////////////////
  // Word assembly

  always_ff @(posedge clk) begin
    if (word_valid) begin
      wr_addr_q <= base_q + wcnt_q;
      wr_last_q <= pair_i.last;
    end

    if (pair_i.valid) begin
      case (in_fmt_i)
        FMT_16BIT: begin
          wr_data_q <= {pair_i.d1_q, pair_i.d1_i, pair_i.d0_q, pair_i.d0_i};
          wr_keep_q <= 8'hff;
        end
        FMT_8BIT: begin
          if (!half_q) begin
            wr_data_q[31:0] <= half8;
            wr_keep_q       <= 8'h0f;
          end else begin
            wr_data_q[63:32] <= half8;
            wr_keep_q        <= 8'hff;
          end
        end
        default: ;
      endcase
    end
  end

  assign wr_o = '{
    valid: wr_valid_q,
    addr:  wr_addr_q,
    data:  wr_data_q,
    keep:  wr_keep_q,
    last:  wr_last_q
  };
  assign skip_toggle_o = toggle_q;

  // A half word only closes a burst
  a_short_word_last: assert property (
    @(posedge clk) disable iff (clk_burst_rst)
      wr_valid_q && (wr_keep_q != 8'hff) |-> wr_last_q
  );

endmodule

`default_nettype wire

/* tb_rxfe.sv */
`default_nettype none

module tb_rxfe
  import rxfe_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int NROWS = 6;

  typedef struct packed {
    logic [12:0] samples_z;
    logic [12:0] words_z;
    logic [2:0]  ch_fmt;
    logic [1:0]  in_fmt;
    logic [9:0]  total;
    logic        thr_en;
    logic [7:0]  num_send;
    logic [7:0]  num_skip;
    logic        en_bit;
    logic        tpat;
    logic        gaps;
    logic [15:0] n_samples;
    logic [3:0]  n_release;
    logic [15:0] n_samples2;
  } row_t;

  logic                      clk;
  logic                      clk_burst_rst;
  logic                      cmd_valid;
  logic [31:0]               cmd_data;
  logic                      timer_rst;
  logic                      in_valid;
  logic [LANES*SAMPLE_W-1:0] in_data;
  logic                      release_pulse;
  ram_wr_t                   m_wr;
  logic                      running;
  logic                      phy_enable;
  logic                      test_pattern;
  logic [3:0]                ch_enabled;
  burst_ptr_t                avail_z;
  logic                      fill;
  logic                      skip;

  row_t       rows [NROWS];
  string      names [NROWS];
  logic [3:0] mask_tab [8];
  ram_wr_t    exp_q [$];
  ram_wr_t    got_exp;
  string      cur_name;
  int         seed;
  int         cycles = 0;
  int         limit;

  // Reference model state
  int          scnt;
  int          tcnt;
  logic        skip_phase;
  logic [1:0]  pidx;
  lane_t       d0i;
  lane_t       d0q;
  lane_t       d1i;
  lane_t       d1q;
  logic        half8;
  logic [63:0] w8;
  logic        first_w;
  logic        skip_b;
  logic        toggle_m;
  int          base;
  int          wcnt;
  int          wptr;
  int          rptr;

  rxfe_top u_dut (
    .clk            (clk),
    .clk_burst_rst  (clk_burst_rst),
    .cmd_valid_i    (cmd_valid),
    .cmd_data_i     (cmd_data),
    .timer_rst_i    (timer_rst),
    .in_valid_i     (in_valid),
    .in_data_i      (in_data),
    .release_i      (release_pulse),
    .m_wr_o         (m_wr),
    .running_o      (running),
    .phy_enable_o   (phy_enable),
    .test_pattern_o (test_pattern),
    .ch_enabled_o   (ch_enabled),
    .avail_z_o      (avail_z),
    .fill_o         (fill),
    .skip_o         (skip)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  ////////////////////
  // Helpers

  task automatic stop_run(input string msg);
    $display("%s", msg);
    $display("tests failed");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic check(input string what, input logic [63:0] exp, input logic [63:0] act);
    if (exp !== act) begin
      stop_run($sformatf("[ERROR] %s %s expected %h actual %h", cur_name, what, exp, act));
    end
  endtask

  function automatic logic [LANES*SAMPLE_W-1:0] sample_word(input int k);
    logic [LANES*SAMPLE_W-1:0] w;
    for (int l = 0; l < LANES; l++) begin
      w[l*SAMPLE_W +: SAMPLE_W] = 12'(k * 4 + l);
    end
    return w;
  endfunction

  function automatic logic [63:0] byte_mask(input logic [7:0] keep);
    logic [63:0] m;
    for (int b = 0; b < 8; b++) begin
      m[b*8 +: 8] = {8{keep[b]}};
    end
    return m;
  endfunction

  function automatic logic [31:0] format_cmd(input logic [9:0] total, input logic [12:0] wz,
                                             input logic [2:0] ch, input logic [1:0] fmt);
    return {CMD_BURST_FORMAT, total, wz, ch, fmt};
  endfunction

  function automatic logic [31:0] reset_cmd(input logic brst, input logic stop, input logic en,
                                            input logic tp, input stream_cmd_e sc);
    return {CMD_RESET, 12'd0, brst, stop, en, tp, 9'd0, sc};
  endfunction

  task automatic send_cmd(input logic [31:0] d);
    @(posedge clk);
    cmd_valid <= 1'b1;
    cmd_data  <= d;
    @(posedge clk);
    cmd_valid <= 1'b0;
  endtask

  task automatic apply_reset();
    @(posedge clk);
    clk_burst_rst <= 1'b1;
    repeat (10) @(posedge clk);
    clk_burst_rst <= 1'b0;
    tcnt       = 0;
    skip_phase = 1'b0;
    pidx       = 2'd0;
    half8      = 1'b0;
    first_w    = 1'b1;
    skip_b     = 1'b0;
    toggle_m   = 1'b0;
    base       = 0;
    wcnt       = 0;
    wptr       = 0;
    rptr       = 0;
    @(negedge clk);
    check("wr valid after reset", 64'(0), 64'(m_wr.valid));
    check("running after reset", 64'(0), 64'(running));
    check("phy_enable after reset", 64'(0), 64'(phy_enable));
    check("test_pattern after reset", 64'(0), 64'(test_pattern));
    check("skip after reset", 64'(0), 64'(skip));
    check("fill after reset", 64'(0), 64'(fill));
  endtask

  ////////////////////
  // Reference model

  task automatic pack_pair(input row_t r, input logic last);
    logic [63:0] data;
    logic [7:0]  keep;
    logic        wv;
    logic        skip_now;
    ram_wr_t     w;
    if (r.in_fmt == 2'd3) begin
      data = {d1q, d1i, d0q, d0i};
      keep = 8'hff;
      wv   = 1'b1;
    end else begin
      // Top byte of each lane, even pair low half
      if (!half8) begin
        w8[31:0] = {d1q[15:8], d1i[15:8], d0q[15:8], d0i[15:8]};
        keep     = 8'h0f;
      end else begin
        w8[63:32] = {d1q[15:8], d1i[15:8], d0q[15:8], d0i[15:8]};
        keep      = 8'hff;
      end
      data  = w8;
      wv    = half8 || last;
      half8 = !half8 && !last;
    end
    if (wv) begin
      skip_now = first_w ? ((int'(r.total) + rptr - wptr - 1) < 0) : skip_b;
      if (!skip_now) begin
        w = '{valid: 1'b1, addr: word_addr_t'(base + wcnt), data: data, keep: keep, last: last};
        exp_q.push_back(w);
      end
      first_w = last;
      skip_b  = skip_now;
      wcnt    = last ? 0 : wcnt + 1;
      if (last) begin
        if (skip_now) begin
          toggle_m = !toggle_m;
        end else begin
          base = base + int'(r.words_z) + 1;
          wptr = wptr + 1;
        end
      end
    end
  endtask

  task automatic mux_beat(input row_t r, input lane_t [3:0] v, input logic last);
    logic [3:0] mask;
    logic [1:0] lo;
    logic [1:0] hi;
    logic       got;
    logic       full;
    mask = mask_tab[r.ch_fmt];
    lo   = 2'd0;
    hi   = 2'd0;
    got  = 1'b0;
    for (int c = 0; c < 4; c++) begin
      if (mask[c]) begin
        if (!got) begin
          lo = 2'(c);
        end
        hi  = 2'(c);
        got = 1'b1;
      end
    end
    if ($countones(mask) == 4) begin
      d0i  = v[0];
      d0q  = v[1];
      d1i  = v[2];
      d1q  = v[3];
      full = 1'b1;
    end else if ($countones(mask) == 2) begin
      if (!pidx[0]) begin
        d0i = v[lo];
        d0q = v[hi];
      end else begin
        d1i = v[lo];
        d1q = v[hi];
      end
      full = pidx[0];
    end else begin
      case (pidx)
        2'd0: d0i = v[lo];
        2'd1: d1i = v[lo];
        2'd2: d0q = v[lo];
        default: d1q = v[lo];
      endcase
      full = (pidx == 2'd3);
    end
    if (full || last) begin
      pack_pair(r, last);
    end
    pidx = last ? 2'd0 : pidx + 2'd1;
  endtask

  task automatic frame_beat(input row_t r, input int k);
    lane_t [3:0] v;
    logic        last;
    logic        send;
    for (int l = 0; l < 4; l++) begin
      v[l] = {12'(k * 4 + l), 4'h0};
    end
    send = !(r.thr_en && skip_phase);
    last = (scnt == 0);
    if (last) begin
      scnt = int'(r.samples_z);
      if (r.thr_en) begin
        if (tcnt == 0) begin
          skip_phase = !skip_phase;
          tcnt       = skip_phase ? int'(r.num_skip) : int'(r.num_send);
        end else begin
          tcnt = tcnt - 1;
        end
      end
    end else begin
      scnt = scnt - 1;
    end
    if (send) begin
      mux_beat(r, v, last);
    end
  endtask

  ////////////////////
  // Stimulus

  task automatic drive_samples(input row_t r, input int first, input int count);
    for (int k = first; k < first + count; k++) begin
      if (r.gaps && (($random(seed) & 3) == 0)) begin
        @(posedge clk);
        in_valid <= 1'b0;
      end
      @(posedge clk);
      in_valid <= 1'b1;
      in_data  <= sample_word(k);
      frame_beat(r, k);
    end
    @(posedge clk);
    in_valid <= 1'b0;
  endtask

  task automatic drain();
    while (exp_q.size() != 0) begin
      @(posedge clk);
    end
    repeat (4) @(posedge clk);
    @(negedge clk);
  endtask

  task automatic check_ring();
    check("avail_z", 64'(burst_ptr_t'(wptr - rptr - 1)), 64'(avail_z));
    check("fill", 64'(wptr & 1), 64'(fill));
    check("skip toggle", 64'(toggle_m), 64'(skip));
  endtask

  task automatic control_test();
    cur_name = "control";
    @(posedge clk);
    timer_rst <= 1'b1;
    for (int c = 0; c < 8; c++) begin
      send_cmd(format_cmd(10'd4, 13'd0, 3'(c), 2'd3));
      @(negedge clk);
      check("ch_enabled", 64'(mask_tab[c]), 64'(ch_enabled));
    end
    // Start stays pending while the timer reset is high
    send_cmd(reset_cmd(1'b1, 1'b0, 1'b1, 1'b0, START_AT));
    repeat (3) @(posedge clk);
    @(negedge clk);
    check("running while timer held", 64'(0), 64'(running));
    @(posedge clk);
    timer_rst <= 1'b0;
    @(posedge clk);
    @(negedge clk);
    check("running after timer release", 64'(1), 64'(running));
    send_cmd(reset_cmd(1'b1, 1'b0, 1'b1, 1'b0, STOP_IMM));
    @(posedge clk);
    @(negedge clk);
    check("running after STOP_IMM", 64'(0), 64'(running));
  endtask

  task automatic run_row(input int i);
    row_t r;
    r        = rows[i];
    cur_name = names[i];
    apply_reset();
    scnt = int'(r.samples_z);
    send_cmd(reset_cmd(1'b1, 1'b0, r.en_bit, r.tpat, IDLE));
    send_cmd({CMD_BURST_SAMPLES, 15'd0, r.samples_z});
    send_cmd(format_cmd(r.total, r.words_z, r.ch_fmt, r.in_fmt));
    send_cmd({CMD_BURST_THROTTLE, 11'd0, r.thr_en, r.num_send, r.num_skip});
    send_cmd(reset_cmd(1'b0, 1'b0, r.en_bit, r.tpat, START_IMM));
    @(posedge clk);
    @(negedge clk);
    check("running", 64'(1), 64'(running));
    check("phy_enable", 64'(!r.en_bit), 64'(phy_enable));
    check("test_pattern", 64'(r.tpat), 64'(test_pattern));
    check("ch_enabled", 64'(mask_tab[r.ch_fmt]), 64'(ch_enabled));
    drive_samples(r, 0, int'(r.n_samples));
    drain();
    check_ring();
    if (r.n_release != 4'd0) begin
      repeat (r.n_release) begin
        @(posedge clk);
        release_pulse <= 1'b1;
        @(posedge clk);
        release_pulse <= 1'b0;
        rptr = rptr + 1;
      end
      @(posedge clk);
      @(negedge clk);
      check_ring();
      drive_samples(r, int'(r.n_samples), int'(r.n_samples2));
      drain();
      check_ring();
    end
    send_cmd(reset_cmd(1'b1, 1'b1, r.en_bit, r.tpat, IDLE));
    @(negedge clk);
    check("running after stop", 64'(0), 64'(running));
  endtask

  ////////////////////
  // Write monitor

  always @(negedge clk) begin
    if (m_wr.valid === 1'b1) begin
      if (exp_q.size() == 0) begin
        stop_run($sformatf("RAM write at address %h in %s was not expected", m_wr.addr, cur_name));
      end else begin
        got_exp = exp_q.pop_front();
        check("addr", 64'(got_exp.addr), 64'(m_wr.addr));
        check("data", got_exp.data & byte_mask(got_exp.keep),
              m_wr.data & byte_mask(got_exp.keep));
        check("keep", 64'(got_exp.keep), 64'(m_wr.keep));
        check("last", 64'(got_exp.last), 64'(m_wr.last));
      end
    end
  end

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles > limit) begin
      stop_run("timeout, the run went past its cycle limit");
    end
  end

  initial begin
    seed          = 32'h16c5_64f1;
    clk_burst_rst = 1'b1;
    cmd_valid     = 1'b0;
    cmd_data      = '0;
    timer_rst     = 1'b0;
    in_valid      = 1'b0;
    in_data       = '0;
    release_pulse = 1'b0;
    mask_tab = '{4'b1111, 4'b0011, 4'b0001, 4'b0010, 4'b0101, 4'b1100, 4'b0100, 4'b1000};

    // samples_z words_z ch fmt total thr send skip en tp gaps n rel n2
    rows[0] = '{13'd7, 13'd9, 3'd0, 2'd3, 10'd16, 1'b0, 8'd0, 8'd0,
                1'b1, 1'b0, 1'b0, 16'd24, 4'd0, 16'd0};
    rows[1] = '{13'd7, 13'd3, 3'd4, 2'd3, 10'd16, 1'b0, 8'd0, 8'd0,
                1'b1, 1'b0, 1'b0, 16'd16, 4'd0, 16'd0};
    rows[2] = '{13'd7, 13'd1, 3'd3, 2'd3, 10'd16, 1'b0, 8'd0, 8'd0,
                1'b0, 1'b1, 1'b0, 16'd16, 4'd0, 16'd0};
    rows[3] = '{13'd4, 13'd2, 3'd0, 2'd1, 10'd16, 1'b0, 8'd0, 8'd0,
                1'b0, 1'b1, 1'b0, 16'd15, 4'd0, 16'd0};
    rows[4] = '{13'd3, 13'd3, 3'd0, 2'd3, 10'd16, 1'b1, 8'd1, 8'd1,
                1'b1, 1'b0, 1'b1, 16'd40, 4'd0, 16'd0};
    rows[5] = '{13'd3, 13'd3, 3'd0, 2'd3, 10'd2, 1'b0, 8'd0, 8'd0,
                1'b1, 1'b0, 1'b0, 16'd12, 4'd1, 16'd8};
    names = '{"fmt16_4ch", "fmt16_ch02", "fmt16_ch1", "fmt8_odd", "throttle", "ring_full"};

    // Samples counted twice to cover random input gaps
    limit = 100;
    for (int i = 0; i < NROWS; i++) begin
      limit = limit + 2 * (int'(rows[i].n_samples) + int'(rows[i].n_samples2)) + 50;
    end

    apply_reset();
    control_test();
    for (int i = 0; i < NROWS; i++) begin
      run_row(i);
    end
    $display("all tests passed");
    $finish;
  end

endmodule

`default_nettype wire
